// File: hw/soc_pkg.sv
package soc_pkg;

	// ==============================
	// Widths
	// ==============================

	localparam int BUS_W = 32;
	// Offset inside one 256 MB region
	localparam int OFFSET_W = 28;

	// Region number in address bits 31..28
	typedef enum logic [3:0] {
		REGION_RAM = 4'h2,
		REGION_BRIDGE = 4'h5,
		REGION_UNMAPPED = 4'hf
	} region_e;

	// Far region in bridge offset bits 27..24
	typedef enum logic [3:0] {
		FAR_DMA = 4'h7,
		FAR_SYSREG = 4'h9
	} far_sel_e;

	// System register index in offset bits 3..2
	typedef enum logic [1:0] {
		SYSREG_LEDS = 2'd0,
		SYSREG_DEVICE_ID = 2'd1,
		SYSREG_RAM_SIZE = 2'd2
	} sysreg_e;

	// DMA register index in offset bits 3..2
	typedef enum logic [1:0] {
		DMA_SRC = 2'd0,
		DMA_DST = 2'd1,
		DMA_COUNT = 2'd2
	} dma_reg_e;

	// ==============================
	// Bus structs
	// ==============================

	typedef struct packed {
		logic request;
		logic [BUS_W-1:0] address;
	} fetch_req_t;

	// rw is 1 for a write
	typedef struct packed {
		logic request;
		logic rw;
		logic [BUS_W-1:0] address;
		logic [BUS_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [BUS_W-1:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic request;
		logic rw;
		logic [OFFSET_W-1:0] offset;
		logic [BUS_W-1:0] wdata;
	} far_req_t;

endpackage

// File: hw/bus_arbiter.sv
module bus_arbiter (
	input logic i_clock,
	input logic i_rst,

	// Instruction fetch port
	input soc_pkg::fetch_req_t i_fetch,
	output soc_pkg::bus_rsp_t o_fetch,

	// Data port
	input soc_pkg::bus_req_t i_data,
	output soc_pkg::bus_rsp_t o_data,

	// DMA port
	input soc_pkg::bus_req_t i_dma,
	output soc_pkg::bus_rsp_t o_dma,

	// Shared system bus
	output soc_pkg::bus_req_t o_bus,
	input soc_pkg::bus_rsp_t i_bus
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_FETCH,
		OWN_DATA,
		OWN_DMA
	} owner_e;

	owner_e owner_q;
	owner_e last_q;
	owner_e grant;
	bus_req_t grant_req;
	bus_req_t bus_q;

	// Round-robin pick with the port after the last winner tried first
	always_comb begin
		case (last_q)
			OWN_FETCH: grant = i_data.request ? OWN_DATA :
				i_dma.request ? OWN_DMA :
				i_fetch.request ? OWN_FETCH : OWN_NONE;
			OWN_DATA: grant = i_dma.request ? OWN_DMA :
				i_fetch.request ? OWN_FETCH :
				i_data.request ? OWN_DATA : OWN_NONE;
			default: grant = i_fetch.request ? OWN_FETCH :
				i_data.request ? OWN_DATA :
				i_dma.request ? OWN_DMA : OWN_NONE;
		endcase
	end

	// Request of the winning port
	always_comb begin
		case (grant)
			OWN_FETCH: begin
				// Fetch is read only
				grant_req.request = 1'b1;
				grant_req.rw = 1'b0;
				grant_req.address = i_fetch.address;
				grant_req.wdata = '0;
			end
			OWN_DATA: grant_req = i_data;
			default: grant_req = i_dma;
		endcase
	end

	// ==============================
	// Ownership and bus register
	// ==============================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			owner_q <= OWN_NONE;
			// Fetch port is tried first after reset
			last_q <= OWN_DMA;
			bus_q.request <= 1'b0;
		end else if (owner_q == OWN_NONE) begin
			if (grant != OWN_NONE) begin
				owner_q <= grant;
				last_q <= grant;
				bus_q <= grant_req;
			end
		end else if (i_bus.ready) begin
			// Back to idle for one cycle
			owner_q <= OWN_NONE;
			bus_q.request <= 1'b0;
		end
	end

	assign o_bus = bus_q;

	// Response goes back to the owner only
	assign o_fetch = '{ready: i_bus.ready && (owner_q == OWN_FETCH), rdata: i_bus.rdata};
	assign o_data = '{ready: i_bus.ready && (owner_q == OWN_DATA), rdata: i_bus.rdata};
	assign o_dma = '{ready: i_bus.ready && (owner_q == OWN_DMA), rdata: i_bus.rdata};

endmodule

// File: hw/bus_decode.sv
module bus_decode (
	input logic i_clock,
	input logic i_rst,

	input soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus,

	output soc_pkg::bus_req_t o_ram,
	input soc_pkg::bus_rsp_t i_ram,

	output soc_pkg::bus_req_t o_bridge,
	input soc_pkg::bus_rsp_t i_bridge
);
	import soc_pkg::*;

	region_e region;
	bus_req_t slave_req;
	logic unmapped_ready;

	always_comb begin
		case (i_bus.address[BUS_W-1:OFFSET_W])
			REGION_RAM: region = REGION_RAM;
			REGION_BRIDGE: region = REGION_BRIDGE;
			default: region = REGION_UNMAPPED;
		endcase
	end

	// Slaves see only the offset inside their region
	always_comb begin
		slave_req = i_bus;
		slave_req.address = {{(BUS_W-OFFSET_W){1'b0}}, i_bus.address[OFFSET_W-1:0]};
		o_ram = slave_req;
		o_ram.request = i_bus.request && (region == REGION_RAM);
		o_bridge = slave_req;
		o_bridge.request = i_bus.request && (region == REGION_BRIDGE);
	end

	// Unmapped responder keeps a stray address from hanging the bus
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= i_bus.request && (region == REGION_UNMAPPED) && !unmapped_ready;
		end
	end

	always_comb begin
		case (region)
			REGION_RAM: o_bus = i_ram;
			REGION_BRIDGE: o_bus = i_bridge;
			default: o_bus = '{ready: unmapped_ready, rdata: '0};
		endcase
	end

endmodule

// File: hw/main_ram.sv
module main_ram #(
	parameter int RAM_WORDS = 1024
) (
	input logic i_clock,
	input logic i_rst,
	input soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus
);
	import soc_pkg::*;

	// RAM_WORDS is a power of two, so the index wraps
	localparam int IDX_W = $clog2(RAM_WORDS);

	logic [BUS_W-1:0] mem [RAM_WORDS];
	logic [IDX_W-1:0] index;
	logic [BUS_W-1:0] rdata_q;
	logic ready_q;

	// Word address
	assign index = i_bus.address[IDX_W+1:2];

	always_ff @(posedge i_clock) begin
		if (i_bus.request && !ready_q) begin
			if (i_bus.rw) begin
				mem[index] <= i_bus.wdata;
			end
			rdata_q <= mem[index];
		end
	end

	// One ready pulse per access
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= i_bus.request && !ready_q;
		end
	end

	assign o_bus = '{ready: ready_q, rdata: rdata_q};

endmodule

// File: hw/periph_bridge.sv
module periph_bridge #(
	parameter int RAM_WORDS = 1024,
	parameter int DEVICE_ID = 3
) (
	input logic i_clock,
	input logic i_rst,

	// Near side
	input soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus,

	// Far DMA register block
	output soc_pkg::far_req_t o_dma,
	input soc_pkg::bus_rsp_t i_dma,

	output logic [7:0] o_leds
);
	import soc_pkg::*;

	far_req_t far_q;
	logic far_ready;
	logic sel_dma;
	logic sel_sysreg;
	logic local_ready;
	logic [BUS_W-1:0] local_rdata;
	logic [7:0] leds_q;

	// Near to far register held until the far side answers
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			far_q.request <= 1'b0;
		end else if (far_ready) begin
			far_q.request <= 1'b0;
		end else if (i_bus.request) begin
			far_q.request <= 1'b1;
			far_q.rw <= i_bus.rw;
			far_q.offset <= i_bus.address[OFFSET_W-1:0];
			far_q.wdata <= i_bus.wdata;
		end
	end

	// Far decode
	assign sel_dma = far_q.offset[OFFSET_W-1 -: 4] == FAR_DMA;
	assign sel_sysreg = far_q.offset[OFFSET_W-1 -: 4] == FAR_SYSREG;

	always_comb begin
		o_dma = far_q;
		o_dma.request = far_q.request && sel_dma;
	end

	// ==============================
	// System registers
	// ==============================

	// Also answers unknown far regions
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			local_ready <= 1'b0;
			leds_q <= '0;
		end else begin
			local_ready <= far_q.request && !sel_dma && !local_ready;
			if (far_q.request && !local_ready && sel_sysreg && far_q.rw &&
				far_q.offset[3:2] == SYSREG_LEDS) begin
				leds_q <= far_q.wdata[7:0];
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!sel_sysreg) begin
			local_rdata <= '0;
		end else begin
			case (far_q.offset[3:2])
				SYSREG_LEDS: local_rdata <= BUS_W'(leds_q);
				SYSREG_DEVICE_ID: local_rdata <= BUS_W'(DEVICE_ID);
				// Size in bytes
				SYSREG_RAM_SIZE: local_rdata <= BUS_W'(RAM_WORDS * 4);
				default: local_rdata <= '0;
			endcase
		end
	end

	assign far_ready = sel_dma ? i_dma.ready : local_ready;
	assign o_bus = sel_dma ? i_dma : '{ready: local_ready, rdata: local_rdata};
	assign o_leds = leds_q;

endmodule

// File: hw/dma_engine.sv
module dma_engine (
	input logic i_clock,
	input logic i_rst,

	// Register access from the bridge
	input soc_pkg::far_req_t i_cfg,
	output soc_pkg::bus_rsp_t o_cfg,

	// Bus master port
	output soc_pkg::bus_req_t o_bus,
	input soc_pkg::bus_rsp_t i_bus
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE
	} state_e;

	state_e state_q;
	logic [BUS_W-1:0] src_q;
	logic [BUS_W-1:0] dst_q;
	logic [BUS_W-1:0] count_q;
	logic [BUS_W-1:0] data_q;
	logic cfg_ready;
	logic [BUS_W-1:0] cfg_rdata;
	logic cfg_write;
	logic busy;

	assign busy = state_q != ST_IDLE;
	assign cfg_write = i_cfg.request && i_cfg.rw && !cfg_ready;

	// ==============================
	// Register block
	// ==============================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			cfg_ready <= 1'b0;
		end else begin
			cfg_ready <= i_cfg.request && !cfg_ready;
		end
	end

	always_ff @(posedge i_clock) begin
		case (i_cfg.offset[3:2])
			DMA_SRC: cfg_rdata <= src_q;
			DMA_DST: cfg_rdata <= dst_q;
			DMA_COUNT: cfg_rdata <= count_q;
			default: cfg_rdata <= '0;
		endcase
	end

	assign o_cfg = '{ready: cfg_ready, rdata: cfg_rdata};

	// ==============================
	// Copy FSM
	// ==============================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state_q <= ST_IDLE;
			src_q <= '0;
			dst_q <= '0;
			count_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					// Nonzero count starts a copy
					if (count_q != '0) begin
						state_q <= ST_READ;
					end
				end
				ST_READ: begin
					if (i_bus.ready) begin
						src_q <= src_q + 32'd4;
						state_q <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					if (i_bus.ready) begin
						dst_q <= dst_q + 32'd4;
						count_q <= (count_q == '0) ? '0 : count_q - 1'b1;
						state_q <= (count_q > 1) ? ST_READ : ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
			// Bridge writes win over the FSM update
			if (cfg_write) begin
				case (i_cfg.offset[3:2])
					DMA_SRC: src_q <= busy ? src_q : i_cfg.wdata;
					DMA_DST: dst_q <= busy ? dst_q : i_cfg.wdata;
					DMA_COUNT: count_q <= i_cfg.wdata;
					default: ;
				endcase
			end
		end
	end

	// Word in flight between read and write
	always_ff @(posedge i_clock) begin
		if (state_q == ST_READ && i_bus.ready) begin
			data_q <= i_bus.rdata;
		end
	end

	always_comb begin
		o_bus.request = (state_q == ST_READ) || (state_q == ST_WRITE);
		o_bus.rw = state_q == ST_WRITE;
		o_bus.address = (state_q == ST_WRITE) ? dst_q : src_q;
		o_bus.wdata = data_q;
	end

endmodule

// File: hw/soc_top.sv
module soc_top #(
	parameter int RAM_WORDS = 1024,
	parameter int DEVICE_ID = 3
) (
	input logic i_clock,
	input logic i_rst,

	// CPU side buses
	input soc_pkg::fetch_req_t i_fetch,
	output soc_pkg::bus_rsp_t o_fetch,
	input soc_pkg::bus_req_t i_data,
	output soc_pkg::bus_rsp_t o_data,

	output logic [7:0] o_leds
);
	import soc_pkg::*;

	// DMA master
	bus_req_t dma_req;
	bus_rsp_t dma_rsp;

	// Shared system bus
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	// Slaves
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t bridge_req;
	bus_rsp_t bridge_rsp;
	far_req_t dma_cfg_req;
	bus_rsp_t dma_cfg_rsp;

	// ==============================
	// Bus
	// ==============================

	bus_arbiter arbiter (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_fetch(i_fetch),
		.o_fetch(o_fetch),
		.i_data(i_data),
		.o_data(o_data),
		.i_dma(dma_req),
		.o_dma(dma_rsp),
		.o_bus(bus_req),
		.i_bus(bus_rsp)
	);

	bus_decode decode (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_bus(bus_req),
		.o_bus(bus_rsp),
		.o_ram(ram_req),
		.i_ram(ram_rsp),
		.o_bridge(bridge_req),
		.i_bridge(bridge_rsp)
	);

	// ==============================
	// Slaves
	// ==============================

	main_ram #(
		.RAM_WORDS(RAM_WORDS)
	) ram (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_bus(ram_req),
		.o_bus(ram_rsp)
	);

	periph_bridge #(
		.RAM_WORDS(RAM_WORDS),
		.DEVICE_ID(DEVICE_ID)
	) bridge (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_bus(bridge_req),
		.o_bus(bridge_rsp),
		.o_dma(dma_cfg_req),
		.i_dma(dma_cfg_rsp),
		.o_leds(o_leds)
	);

	dma_engine dma (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_cfg(dma_cfg_req),
		.o_cfg(dma_cfg_rsp),
		.o_bus(dma_req),
		.i_bus(dma_rsp)
	);

endmodule

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Included in the testbench body after soc_pkg is imported and after
// clock, data_req, data_rsp, fetch_req and fetch_rsp are declared

// ==============================
// Reference model
// ==============================

// Main RAM contents keyed by word index
logic [31:0] model_ram [int unsigned];
logic [7:0] model_leds;

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (actual !== expected) begin
		$display("ERR %s expected %h actual %h", name, expected, actual);
		$display("Done: errors found");
		$fatal(1);
	end
endtask

// One access on the data port up to its ready pulse
task automatic data_access(input logic rw, input logic [31:0] address,
	input logic [31:0] wdata, output logic [31:0] rdata);
	@(posedge clock);
	data_req <= '{request: 1'b1, rw: rw, address: address, wdata: wdata};
	do @(posedge clock); while (!data_rsp.ready);
	rdata = data_rsp.rdata;
	data_req.request <= 1'b0;
endtask

// Read on the fetch port
task automatic fetch_read(input logic [31:0] address, output logic [31:0] rdata);
	@(posedge clock);
	fetch_req <= '{request: 1'b1, address: address};
	do @(posedge clock); while (!fetch_rsp.ready);
	rdata = fetch_rsp.rdata;
	fetch_req.request <= 1'b0;
endtask

`endif

// File: test/tb_soc.sv
module tb_soc;
	import soc_pkg::*;

	localparam int RAM_WORDS = 1024;
	localparam int DEVICE_ID = 3;
	localparam logic [31:0] RAM_BASE = 32'h2000_0000;
	localparam logic [31:0] DMA_BASE = 32'h5700_0000;
	localparam logic [31:0] SYSREG_BASE = 32'h5900_0000;
	// About 400 accesses at 40 cycles worst case, plus DMA copies
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int MIXED_LEN = 48;

	logic clock;
	logic rst;
	fetch_req_t fetch_req;
	bus_rsp_t fetch_rsp;
	bus_req_t data_req;
	bus_rsp_t data_rsp;
	logic [7:0] leds;
	integer seed;
	int cycle_count;
	int unsigned written_q[$];
	int unsigned mixed_widx [MIXED_LEN];
	logic [31:0] mixed_wval [MIXED_LEN];
	int unsigned mixed_fidx [MIXED_LEN];

	`include "tb_checks.svh"

	soc_top #(
		.RAM_WORDS(RAM_WORDS),
		.DEVICE_ID(DEVICE_ID)
	) dut0 (
		.i_clock(clock),
		.i_rst(rst),
		.i_fetch(fetch_req),
		.o_fetch(fetch_rsp),
		.i_data(data_req),
		.o_data(data_rsp),
		.o_leds(leds)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, a bus access never completed", cycle_count);
		$display("Done: errors found");
		$fatal(1);
	end

	// ==============================
	// Helpers
	// ==============================

	function automatic int unsigned pick_index(input int unsigned base, input int unsigned span);
		return base + ($unsigned($random(seed)) % span);
	endfunction

	function automatic logic [31:0] word_address(input int unsigned idx);
		return RAM_BASE + 32'(idx << 2);
	endfunction

	task automatic write_word(input int unsigned idx, input logic [31:0] value);
		logic [31:0] unused;
		data_access(1'b1, word_address(idx), value, unused);
		model_ram[idx] = value;
	endtask

	task automatic verify_word(input int unsigned idx);
		logic [31:0] rdata;
		data_access(1'b0, word_address(idx), '0, rdata);
		check_value($sformatf("ram[%0d]", idx), model_ram[idx], rdata);
	endtask

	task automatic reg_write(input logic [31:0] address, input logic [31:0] value);
		logic [31:0] unused;
		data_access(1'b1, address, value, unused);
	endtask

	// One DMA copy over the word ranges at src and dst
	task automatic run_dma_copy(input int unsigned src, input int unsigned dst);
		int unsigned count;
		logic [31:0] value;
		count = pick_index(1, 16);
		for (int i = 0; i < count; i++) begin
			write_word(src + i, $random(seed));
		end
		reg_write(DMA_BASE + 32'h0, word_address(src));
		reg_write(DMA_BASE + 32'h4, word_address(dst));
		reg_write(DMA_BASE + 32'h8, count);
		// Copy ends when COUNT reads zero
		do begin
			data_access(1'b0, DMA_BASE + 32'h8, '0, value);
		end while (value != '0);
		data_access(1'b0, DMA_BASE + 32'h0, '0, value);
		check_value("dma_src", word_address(src + count), value);
		for (int i = 0; i < count; i++) begin
			model_ram[dst + i] = model_ram[src + i];
			verify_word(dst + i);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int unsigned idx;
		logic [31:0] value;
		logic [31:0] stray;
		seed = 32'h3422_4ab0;
		rst = 1'b1;
		data_req = '0;
		fetch_req = '0;
		repeat (4) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		check_value("o_leds", 32'h0, leds);
		check_value("data_ready", 32'h0, data_rsp.ready);
		check_value("fetch_ready", 32'h0, fetch_rsp.ready);

		// Random writes then reads in the lower half of RAM
		for (int i = 0; i < 64; i++) begin
			idx = pick_index(0, 512);
			write_word(idx, $random(seed));
			written_q.push_back(idx);
		end
		foreach (written_q[i]) begin
			verify_word(written_q[i]);
		end

		// Data writes above word 511 race fetches of words already written
		for (int i = 0; i < MIXED_LEN; i++) begin
			mixed_widx[i] = pick_index(512, 256);
			mixed_wval[i] = $random(seed);
			mixed_fidx[i] = written_q[pick_index(0, written_q.size())];
		end
		fork
			begin
				for (int i = 0; i < MIXED_LEN; i++) begin
					write_word(mixed_widx[i], mixed_wval[i]);
				end
			end
			begin
				logic [31:0] rdata;
				for (int i = 0; i < MIXED_LEN; i++) begin
					fetch_read(word_address(mixed_fidx[i]), rdata);
					check_value($sformatf("fetch[%0d]", mixed_fidx[i]),
						model_ram[mixed_fidx[i]], rdata);
				end
			end
		join

		// System registers
		value = $random(seed);
		reg_write(SYSREG_BASE + 32'h0, value);
		model_leds = value[7:0];
		check_value("o_leds", {24'h0, model_leds}, leds);
		data_access(1'b0, SYSREG_BASE + 32'h0, '0, value);
		check_value("leds_reg", {24'h0, model_leds}, value);
		data_access(1'b0, SYSREG_BASE + 32'h4, '0, value);
		check_value("device_id", DEVICE_ID, value);
		data_access(1'b0, SYSREG_BASE + 32'h8, '0, value);
		check_value("ram_size", 32'd4096, value);

		for (int k = 0; k < 3; k++) begin
			run_dma_copy(800 + k * 64, 832 + k * 64);
		end

		// Unmapped regions read zero and never reach RAM
		data_access(1'b0, 32'h0000_0040, '0, value);
		check_value("unmapped_r0", 32'h0, value);
		data_access(1'b0, 32'h7000_0100, '0, value);
		check_value("unmapped_r7", 32'h0, value);
		stray = word_address(written_q[0]);
		reg_write({4'h0, stray[27:0]}, $random(seed));
		reg_write({4'h7, stray[27:0]}, $random(seed));
		// Same offset as LEDS behind the bridge
		reg_write({4'h7, 28'h900_0000}, {24'h0, ~model_leds});
		foreach (model_ram[k]) begin
			verify_word(k);
		end
		check_value("o_leds", {24'h0, model_leds}, leds);

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
hw/soc_pkg.sv
hw/bus_arbiter.sv
hw/bus_decode.sv
hw/main_ram.sv
hw/periph_bridge.sv
hw/dma_engine.sv
hw/soc_top.sv
test/tb_soc.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - hw/soc_pkg.sv
  - hw/bus_arbiter.sv
  - hw/bus_decode.sv
  - hw/main_ram.sv
  - hw/periph_bridge.sv
  - hw/dma_engine.sv
  - hw/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_soc.sv
